/* verilog/exe_config.svh */
// Execute subsystem configuration: data path and register address widths
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// Integer data path width, RV32I
`define XLEN 32

// Register file address width
// 32 architectural registers
`define RF_AWIDTH 5

`endif

/* verilog/exe_pkg.sv */
// Execute subsystem types: ALU, branch and select encodings plus stage-to-stage structs
`default_nettype none
`include "exe_config.svh"

package exe_pkg;

    // ALU operation
    typedef enum logic [3:0] {
        ALU_OPS_ADD       = 4'd0,
        ALU_OPS_SUB       = 4'd1,
        ALU_OPS_AND       = 4'd2,
        ALU_OPS_OR        = 4'd3,
        ALU_OPS_XOR       = 4'd4,
        ALU_OPS_SLL       = 4'd5,
        ALU_OPS_SRL       = 4'd6,
        ALU_OPS_SRA       = 4'd7,
        ALU_OPS_SLT       = 4'd8,
        ALU_OPS_SLTU      = 4'd9,
        ALU_OPS_COPY_OPR1 = 4'd10,
        ALU_OPS_COPY_OPR2 = 4'd11
    } type_alu_ops_e;

    // Branch condition, NONE for non-branch instructions
    typedef enum logic [2:0] {
        BR_OPS_NONE = 3'd0,
        BR_OPS_EQ   = 3'd1,
        BR_OPS_NE   = 3'd2,
        BR_OPS_LT   = 3'd3,
        BR_OPS_GE   = 3'd4,
        BR_OPS_LTU  = 3'd5,
        BR_OPS_GEU  = 3'd6
    } type_br_ops_e;

    // ALU operand 1 source
    typedef enum logic {
        ALU_OPR1_REG = 1'b0,
        ALU_OPR1_PC  = 1'b1
    } type_opr1_sel_e;

    // ALU operand 2 source
    typedef enum logic {
        ALU_OPR2_REG = 1'b0,
        ALU_OPR2_IMM = 1'b1
    } type_opr2_sel_e;

    // Comparator operand 2 source, immediate for SLTI and SLTIU
    typedef enum logic {
        CMP_OPR2_REG = 1'b0,
        CMP_OPR2_IMM = 1'b1
    } type_cmp_opr2_sel_e;

    // Decode to execute control
    typedef struct packed {
        logic               valid;
        type_alu_ops_e      alu_ops;
        type_br_ops_e       branch_ops;
        type_opr1_sel_e     alu_opr1_sel;
        type_opr2_sel_e     alu_opr2_sel;
        type_cmp_opr2_sel_e alu_cmp_opr2_sel;
        logic               branch_req;
        logic               jump_req;
        logic               rd_wr_req;
    } type_id2exe_ctrl_s;

    // Decode to execute data
    typedef struct packed {
        logic [31:0]        instr;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   pc_next;
        logic [`XLEN-1:0]   imm;
        logic [`XLEN-1:0]   rs1_data;
        logic [`XLEN-1:0]   rs2_data;
    } type_id2exe_data_s;

    // Execute sources seen by the forwarding unit
    typedef struct packed {
        logic [`RF_AWIDTH-1:0] rs1_addr;
        logic [`RF_AWIDTH-1:0] rs2_addr;
        logic                  use_rs1;
        logic                  use_rs2;
    } type_exe2fwd_s;

    // Forward selects back to execute
    typedef struct packed {
        logic fwd_lsu_rs1;
        logic fwd_lsu_rs2;
        logic fwd_wrb_rs1;
        logic fwd_wrb_rs2;
    } type_fwd2exe_s;

    // Execute to memory stage
    typedef struct packed {
        logic                  valid;
        logic [`RF_AWIDTH-1:0] rd_addr;
        logic                  rd_wr_req;
        logic [`XLEN-1:0]      alu_result;
    } type_exe2lsu_s;

    // Register write port, used for memory and writeback stage contents
    typedef struct packed {
        logic                  rd_wr_req;
        logic [`RF_AWIDTH-1:0] rd_addr;
        logic [`XLEN-1:0]      rd_data;
    } type_wrb_s;

    // Redirect request to fetch
    typedef struct packed {
        logic             new_pc_req;
        logic [`XLEN-1:0] pc_new;
    } type_exe2if_fb_s;

endpackage : exe_pkg

`default_nettype wire

/* verilog/forward_unit.sv */
// Forwarding unit: RAW hazard detection against the memory and writeback stages
`timescale 1ns/10ps
`default_nettype none
`include "exe_config.svh"

module forward_unit
    import exe_pkg::*;
(
    // Execute sources
    input  type_exe2fwd_s exe2fwd_i,

    // Destinations of the two later stages
    input  type_wrb_s     lsu2fwd_i,
    input  type_wrb_s     wrb2fwd_i,

    // Forward selects
    output type_fwd2exe_s fwd2exe_o
);

    // Stage writes a nonzero rd that the operand reads
    function automatic logic rd_hit(input type_wrb_s stage,
                                    input logic [`RF_AWIDTH-1:0] rs_addr,
                                    input logic use_rs);
        rd_hit = use_rs & stage.rd_wr_req & (|stage.rd_addr)
               & (stage.rd_addr == rs_addr);
    endfunction

    logic lsu_rs1_hit;
    logic lsu_rs2_hit;
    logic wrb_rs1_hit;
    logic wrb_rs2_hit;

    assign lsu_rs1_hit = rd_hit(lsu2fwd_i, exe2fwd_i.rs1_addr, exe2fwd_i.use_rs1);
    assign lsu_rs2_hit = rd_hit(lsu2fwd_i, exe2fwd_i.rs2_addr, exe2fwd_i.use_rs2);
    assign wrb_rs1_hit = rd_hit(wrb2fwd_i, exe2fwd_i.rs1_addr, exe2fwd_i.use_rs1);
    assign wrb_rs2_hit = rd_hit(wrb2fwd_i, exe2fwd_i.rs2_addr, exe2fwd_i.use_rs2);

    // Memory stage holds the younger value
    assign fwd2exe_o.fwd_lsu_rs1 = lsu_rs1_hit;
    assign fwd2exe_o.fwd_lsu_rs2 = lsu_rs2_hit;
    // Writeback only when the memory stage does not match
    assign fwd2exe_o.fwd_wrb_rs1 = wrb_rs1_hit & ~lsu_rs1_hit;
    assign fwd2exe_o.fwd_wrb_rs2 = wrb_rs2_hit & ~lsu_rs2_hit;

endmodule : forward_unit

`default_nettype wire

/* verilog/execute.sv */
// Execute stage: forwarded operand select, ALU, branch compare and fetch redirect
`timescale 1ns/10ps
`default_nettype none
`include "exe_config.svh"

module execute
    import exe_pkg::*;
(
    // Decoded instruction
    input  type_id2exe_ctrl_s id2exe_ctrl_i,
    input  type_id2exe_data_s id2exe_data_i,

    // Forwarding unit
    input  type_fwd2exe_s     fwd2exe_i,
    output type_exe2fwd_s     exe2fwd_o,

    // Results of the two later stages
    input  type_wrb_s         lsu2exe_fb_i,
    input  type_wrb_s         wrb2exe_fb_i,

    // Memory stage
    output type_exe2lsu_s     exe2lsu_o,

    // Fetch redirect
    output type_exe2if_fb_s   exe2if_fb_o
);

    localparam int SHAMT_W = $clog2(`XLEN);

    // Register operands after forwarding
    logic [`XLEN-1:0] opr_rs1_data;
    logic [`XLEN-1:0] opr_rs2_data;

    // ALU operands and result
    logic [`XLEN-1:0] alu_opr1;
    logic [`XLEN-1:0] alu_opr2;
    logic [`XLEN-1:0] adder_out;
    logic [`XLEN-1:0] alu_result;
    logic [SHAMT_W-1:0] shift_amt;

    // Comparator
    logic [`XLEN-1:0] cmp_opr2;
    logic [`XLEN:0]   cmp_diff;
    logic             cmp_zero;
    logic             cmp_neg;
    logic             cmp_ovf;
    logic             cmp_carry;
    logic             cmp_lt;
    logic             branch_res;

    // Memory stage result wins over writeback, decoded data otherwise
    always_comb begin
        case (1'b1)
            fwd2exe_i.fwd_lsu_rs1: opr_rs1_data = lsu2exe_fb_i.rd_data;
            fwd2exe_i.fwd_wrb_rs1: opr_rs1_data = wrb2exe_fb_i.rd_data;
            default:               opr_rs1_data = id2exe_data_i.rs1_data;
        endcase
    end

    always_comb begin
        case (1'b1)
            fwd2exe_i.fwd_lsu_rs2: opr_rs2_data = lsu2exe_fb_i.rd_data;
            fwd2exe_i.fwd_wrb_rs2: opr_rs2_data = wrb2exe_fb_i.rd_data;
            default:               opr_rs2_data = id2exe_data_i.rs2_data;
        endcase
    end

    // PC for AUIPC and JAL, immediate for I-type and branch targets
    assign alu_opr1 = (id2exe_ctrl_i.alu_opr1_sel == ALU_OPR1_PC) ? id2exe_data_i.pc
                                                                  : opr_rs1_data;
    assign alu_opr2 = (id2exe_ctrl_i.alu_opr2_sel == ALU_OPR2_IMM) ? id2exe_data_i.imm
                                                                   : opr_rs2_data;

    assign shift_amt = alu_opr2[SHAMT_W-1:0];

    // Shared adder, subtracts only for SUB
    assign adder_out = (id2exe_ctrl_i.alu_ops == ALU_OPS_SUB) ? (alu_opr1 - alu_opr2)
                                                              : (alu_opr1 + alu_opr2);

    // Comparator always works on rs1
    assign cmp_opr2 = (id2exe_ctrl_i.alu_cmp_opr2_sel == CMP_OPR2_IMM) ? id2exe_data_i.imm
                                                                       : opr_rs2_data;

    // Extra bit gives the borrow for unsigned compares
    assign cmp_diff  = {1'b0, opr_rs1_data} - {1'b0, cmp_opr2};
    assign cmp_zero  = ~|cmp_diff[`XLEN-1:0];
    assign cmp_neg   = cmp_diff[`XLEN-1];
    assign cmp_carry = cmp_diff[`XLEN];
    // Overflow when the signs differ and the result sign follows the subtrahend
    assign cmp_ovf   = (opr_rs1_data[`XLEN-1] ^ cmp_opr2[`XLEN-1])
                     & (cmp_neg ^ opr_rs1_data[`XLEN-1]);
    assign cmp_lt    = cmp_neg ^ cmp_ovf;

    // Branch condition
    always_comb begin
        case (id2exe_ctrl_i.branch_ops)
            BR_OPS_EQ:  branch_res = cmp_zero;
            BR_OPS_NE:  branch_res = ~cmp_zero;
            BR_OPS_LT:  branch_res = cmp_lt;
            BR_OPS_GE:  branch_res = ~cmp_lt;
            BR_OPS_LTU: branch_res = cmp_carry;
            BR_OPS_GEU: branch_res = ~cmp_carry;
            default:    branch_res = 1'b0;
        endcase
    end

    // ALU result select
    always_comb begin
        case (id2exe_ctrl_i.alu_ops)
            ALU_OPS_ADD,
            ALU_OPS_SUB:       alu_result = adder_out;
            ALU_OPS_AND:       alu_result = alu_opr1 & alu_opr2;
            ALU_OPS_OR:        alu_result = alu_opr1 | alu_opr2;
            ALU_OPS_XOR:       alu_result = alu_opr1 ^ alu_opr2;
            ALU_OPS_SLL:       alu_result = alu_opr1 << shift_amt;
            ALU_OPS_SRL:       alu_result = alu_opr1 >> shift_amt;
            ALU_OPS_SRA:       alu_result = $signed(alu_opr1) >>> shift_amt;
            ALU_OPS_SLT:       alu_result = {{(`XLEN-1){1'b0}}, cmp_lt};
            ALU_OPS_SLTU:      alu_result = {{(`XLEN-1){1'b0}}, cmp_carry};
            ALU_OPS_COPY_OPR1: alu_result = alu_opr1;
            // LUI passes the immediate
            ALU_OPS_COPY_OPR2: alu_result = alu_opr2;
            default:           alu_result = '0;
        endcase
    end

    // Source registers straight from the instruction word
    assign exe2fwd_o.rs1_addr = id2exe_data_i.instr[19:15];
    assign exe2fwd_o.rs2_addr = id2exe_data_i.instr[24:20];

    // Branches compare both registers even with an immediate operand 2
    assign exe2fwd_o.use_rs1 = (id2exe_ctrl_i.alu_opr1_sel == ALU_OPR1_REG)
                             | id2exe_ctrl_i.branch_req;
    assign exe2fwd_o.use_rs2 = (id2exe_ctrl_i.alu_opr2_sel == ALU_OPR2_REG)
                             | id2exe_ctrl_i.branch_req;

    // To memory stage, which qualifies the write with valid
    assign exe2lsu_o.valid     = id2exe_ctrl_i.valid;
    assign exe2lsu_o.rd_addr   = id2exe_data_i.instr[11:7];
    assign exe2lsu_o.rd_wr_req = id2exe_ctrl_i.rd_wr_req;
    // Jumps write the link address
    assign exe2lsu_o.alu_result = id2exe_ctrl_i.jump_req ? id2exe_data_i.pc_next
                                                         : alu_result;

    // Redirect on a jump or a taken branch, never from a bubble
    assign exe2if_fb_o.new_pc_req = id2exe_ctrl_i.valid
                                  & (id2exe_ctrl_i.jump_req
                                  | (id2exe_ctrl_i.branch_req & branch_res));
    // Target from the ALU, pc plus imm for branches and JAL
    assign exe2if_fb_o.pc_new     = alu_result;

endmodule : execute

`default_nettype wire

/* verilog/mem_wrb_pipe.sv */
// Memory and writeback pipeline registers carrying the result to the register write port
`timescale 1ns/10ps
`default_nettype none
`include "exe_config.svh"

module mem_wrb_pipe
    import exe_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n_i,

    // Execute result
    input  type_exe2lsu_s exe2lsu_i,

    // Memory stage contents
    output type_wrb_s     lsu_o,

    // Writeback stage contents, the register write port
    output type_wrb_s     wrb_o
);

    // Memory stage
    logic                  lsu_wr_req;
    logic [`RF_AWIDTH-1:0] lsu_rd_addr;
    logic [`XLEN-1:0]      lsu_rd_data;

    // Writeback stage
    logic                  wrb_wr_req;
    logic [`RF_AWIDTH-1:0] wrb_rd_addr;
    logic [`XLEN-1:0]      wrb_rd_data;

    // Write requests, a bubble never writes
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            lsu_wr_req <= 1'b0;
            wrb_wr_req <= 1'b0;
        end else begin
            lsu_wr_req <= exe2lsu_i.valid & exe2lsu_i.rd_wr_req;
            wrb_wr_req <= lsu_wr_req;
        end
    end

    // Destination and data move along every cycle
    always_ff @(posedge clk) begin
        lsu_rd_addr <= exe2lsu_i.rd_addr;
        lsu_rd_data <= exe2lsu_i.alu_result;
        wrb_rd_addr <= lsu_rd_addr;
        wrb_rd_data <= lsu_rd_data;
    end

    // Memory stage seen by forwarding
    assign lsu_o.rd_wr_req = lsu_wr_req;
    assign lsu_o.rd_addr   = lsu_rd_addr;
    assign lsu_o.rd_data   = lsu_rd_data;

    // Register file write, two cycles after execute
    assign wrb_o.rd_wr_req = wrb_wr_req;
    assign wrb_o.rd_addr   = wrb_rd_addr;
    assign wrb_o.rd_data   = wrb_rd_data;

endmodule : mem_wrb_pipe

`default_nettype wire

/* verilog/exe_subsys_top.sv */
// Execute subsystem top: execute, forwarding and the memory and writeback stages
`timescale 1ns/10ps
`default_nettype none
`include "exe_config.svh"

module exe_subsys_top
    import exe_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,

    // From decode
    input  type_id2exe_ctrl_s id2exe_ctrl_i,
    input  type_id2exe_data_s id2exe_data_i,

    // To fetch
    output type_exe2if_fb_s   exe2if_fb_o,

    // Register write port
    output type_wrb_s         wrb_o
);

    // Forwarding loop
    type_exe2fwd_s exe2fwd;
    type_fwd2exe_s fwd2exe;

    // Execute to memory stage
    type_exe2lsu_s exe2lsu;

    // Memory stage contents, fed back for forwarding
    type_wrb_s     lsu2fwd;

    execute u_execute (
        .id2exe_ctrl_i (id2exe_ctrl_i),
        .id2exe_data_i (id2exe_data_i),
        .fwd2exe_i     (fwd2exe),
        .exe2fwd_o     (exe2fwd),
        .lsu2exe_fb_i  (lsu2fwd),
        .wrb2exe_fb_i  (wrb_o),
        .exe2lsu_o     (exe2lsu),
        .exe2if_fb_o   (exe2if_fb_o)
    );

    forward_unit u_forward_unit (
        .exe2fwd_i (exe2fwd),
        .lsu2fwd_i (lsu2fwd),
        .wrb2fwd_i (wrb_o),
        .fwd2exe_o (fwd2exe)
    );

    // Writeback output also closes the distance-2 forwarding path
    mem_wrb_pipe u_mem_wrb_pipe (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .exe2lsu_i (exe2lsu),
        .lsu_o     (lsu2fwd),
        .wrb_o     (wrb_o)
    );

endmodule : exe_subsys_top

`default_nettype wire

/* verification/tb_exe_ref.svh */
// Reference model for the execute subsystem testbench: ALU, branch, target and LFSR step
`ifndef TB_EXE_REF_SVH
`define TB_EXE_REF_SVH

// ALU result per RV32I rules
// a and b are the ALU operands, c1 and c2 the compare operands
function automatic logic [`XLEN-1:0] alu_ref(input type_alu_ops_e op,
                                             input logic [`XLEN-1:0] a,
                                             input logic [`XLEN-1:0] b,
                                             input logic [`XLEN-1:0] c1,
                                             input logic [`XLEN-1:0] c2);
    logic [`XLEN-1:0] r;
    int sh;
    sh = b % `XLEN;
    case (op)
        ALU_OPS_ADD:       r = a + b;
        ALU_OPS_SUB:       r = a - b;
        ALU_OPS_AND:       r = a & b;
        ALU_OPS_OR:        r = a | b;
        ALU_OPS_XOR:       r = a ^ b;
        ALU_OPS_SLL:       r = a << sh;
        ALU_OPS_SRL:       r = a >> sh;
        ALU_OPS_SRA:       r = $unsigned($signed(a) >>> sh);
        // Set-less-than compares rs1 against rs2 or the immediate
        ALU_OPS_SLT:       r = ($signed(c1) < $signed(c2)) ? 1 : 0;
        ALU_OPS_SLTU:      r = (c1 < c2) ? 1 : 0;
        ALU_OPS_COPY_OPR1: r = a;
        ALU_OPS_COPY_OPR2: r = b;
        default:           r = '0;
    endcase
    return r;
endfunction

// Branch condition outcome
function automatic logic branch_ref(input type_br_ops_e br,
                                    input logic [`XLEN-1:0] x,
                                    input logic [`XLEN-1:0] y);
    logic t;
    case (br)
        BR_OPS_EQ:  t = (x == y);
        BR_OPS_NE:  t = (x != y);
        BR_OPS_LT:  t = ($signed(x) < $signed(y));
        BR_OPS_GE:  t = ($signed(x) >= $signed(y));
        BR_OPS_LTU: t = (x < y);
        BR_OPS_GEU: t = (x >= y);
        default:    t = 1'b0;
    endcase
    return t;
endfunction

// Redirect target for branches and JAL
function automatic logic [`XLEN-1:0] pc_ref(input logic [`XLEN-1:0] pc,
                                            input logic [`XLEN-1:0] imm);
    return pc + imm;
endfunction

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

`endif

/* verification/tb_exe_subsys.sv */
// Testbench for the execute subsystem with decode model, reference queue and result compare
`timescale 1ns/10ps
`default_nettype none
`include "exe_config.svh"

module tb_exe_subsys
    import exe_pkg::*;
;

`include "tb_exe_ref.svh"

    // Expected writeback due in a given cycle
    typedef struct packed {
        logic [31:0] due;
        type_wrb_s   w;
    } exp_s;

    // Expected redirect in the issue cycle
    typedef struct packed {
        logic [31:0]      due;
        logic             req;
        logic [`XLEN-1:0] pc;
    } fb_s;

    logic              clk;
    logic              rst_n_i;
    type_id2exe_ctrl_s id2exe_ctrl_i;
    type_id2exe_data_s id2exe_data_i;
    type_exe2if_fb_s   exe2if_fb_o;
    type_wrb_s         wrb_o;

    logic [31:0]      cyc;
    logic [15:0]      lfsr;
    logic [`XLEN-1:0] arch [0:31];
    logic [`XLEN-1:0] rf [0:31];
    type_wrb_s        pend [$];
    exp_s             exp_q [$];
    fb_s              fb_q [$];
    int               errors;
    int               checks;
    int               n_tests;
    int               err_at_start;
    string            cur_name;

    exe_subsys_top UUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .id2exe_ctrl_i (id2exe_ctrl_i),
        .id2exe_data_i (id2exe_data_i),
        .exe2if_fb_o   (exe2if_fb_o),
        .wrb_o         (wrb_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Cycle count, held at zero in reset
    always @(posedge clk) begin
        if (!rst_n_i) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic type_id2exe_ctrl_s alu_ctrl(input type_alu_ops_e op, input logic use_imm);
        type_id2exe_ctrl_s c;
        c = '0;
        c.valid = 1'b1;
        c.alu_ops = op;
        c.alu_opr2_sel = use_imm ? ALU_OPR2_IMM : ALU_OPR2_REG;
        c.alu_cmp_opr2_sel = use_imm ? CMP_OPR2_IMM : CMP_OPR2_REG;
        c.rd_wr_req = 1'b1;
        return c;
    endfunction

    // Branch target is pc plus imm and the compare uses rs1 and rs2
    function automatic type_id2exe_ctrl_s br_ctrl(input type_br_ops_e br);
        type_id2exe_ctrl_s c;
        c = '0;
        c.valid = 1'b1;
        c.alu_opr1_sel = ALU_OPR1_PC;
        c.alu_opr2_sel = ALU_OPR2_IMM;
        c.branch_ops = br;
        c.branch_req = 1'b1;
        return c;
    endfunction

    // JAL with valid high and a bubble carrying every request with valid low
    function automatic type_id2exe_ctrl_s jal_ctrl(input logic valid);
        type_id2exe_ctrl_s c;
        c = '0;
        c.valid = valid;
        c.alu_opr1_sel = ALU_OPR1_PC;
        c.alu_opr2_sel = ALU_OPR2_IMM;
        c.jump_req = 1'b1;
        c.rd_wr_req = 1'b1;
        c.branch_ops = BR_OPS_EQ;
        c.branch_req = ~valid;
        return c;
    endfunction

    // Architectural state updates now and the register file two instructions behind
    task automatic advance_model(input type_wrb_s w);
        type_wrb_s p;
        if (w.rd_wr_req && w.rd_addr != 0) begin
            arch[w.rd_addr] = w.rd_data;
        end
        pend.push_back(w);
        if (pend.size() > 2) begin
            p = pend.pop_front();
            if (p.rd_wr_req && p.rd_addr != 0) begin
                rf[p.rd_addr] = p.rd_data;
            end
        end
    endtask

    task automatic issue(input type_id2exe_ctrl_s c, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [4:0] rd,
                         input logic [`XLEN-1:0] imm, input logic [`XLEN-1:0] pc);
        type_id2exe_data_s d;
        exp_s e;
        fb_s f;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] c2;
        @(posedge clk);
        #5;
        d.instr = {7'd0, rs2, rs1, 3'd0, rd, 7'h33};
        d.pc = pc;
        d.pc_next = pc + 4;
        d.imm = imm;
        d.rs1_data = rf[rs1];
        d.rs2_data = rf[rs2];
        id2exe_ctrl_i = c;
        id2exe_data_i = d;
        a = (c.alu_opr1_sel == ALU_OPR1_PC) ? pc : arch[rs1];
        b = (c.alu_opr2_sel == ALU_OPR2_IMM) ? imm : arch[rs2];
        c2 = (c.alu_cmp_opr2_sel == CMP_OPR2_IMM) ? imm : arch[rs2];
        f.due = cyc;
        f.req = c.valid & (c.jump_req | (c.branch_req & branch_ref(c.branch_ops, arch[rs1], c2)));
        f.pc = pc_ref(pc, imm);
        fb_q.push_back(f);
        e.due = cyc + 2;
        e.w.rd_wr_req = c.valid & c.rd_wr_req;
        e.w.rd_addr = rd;
        // Jumps write the link address
        e.w.rd_data = c.jump_req ? pc + 4 : alu_ref(c.alu_ops, a, b, arch[rs1], c2);
        exp_q.push_back(e);
        advance_model(e.w);
    endtask

    // Empty slot with nothing expected
    task automatic idle_slot();
        @(posedge clk);
        #5;
        id2exe_ctrl_i = '0;
        advance_model('0);
    endtask

    task automatic begin_test(input string name);
        cur_name = name;
        err_at_start = errors;
    endtask

    task automatic end_test();
        int t;
        t = 0;
        while (exp_q.size() > 0 || fb_q.size() > 0) begin
            if (t == 10) begin
                $display("Timeout in %s: expected results never came out", cur_name);
                errors++;
                break;
            end
            idle_slot();
            t++;
        end
        n_tests++;
        $display("Test %s: %s, %0d mismatches", cur_name,
                 (errors == err_at_start) ? "pass" : "fail", errors - err_at_start);
    endtask

    // Compare in mid cycle where the outputs are stable
    always @(negedge clk) begin
        fb_s  f;
        exp_s e;
        if (fb_q.size() > 0 && fb_q[0].due == cyc) begin
            f = fb_q.pop_front();
            checks++;
            if (exe2if_fb_o.new_pc_req !== f.req) begin
                $display("ERROR at %0t: new_pc_req %b, expected %b", $time,
                         exe2if_fb_o.new_pc_req, f.req);
                errors++;
            end else if (f.req && exe2if_fb_o.pc_new !== f.pc) begin
                $display("ERROR at %0t: pc_new %h, expected %h", $time, exe2if_fb_o.pc_new, f.pc);
                errors++;
            end
        end
        checks++;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            if (wrb_o.rd_wr_req !== e.w.rd_wr_req) begin
                $display("ERROR at %0t: rd_wr_req %b, expected %b", $time,
                         wrb_o.rd_wr_req, e.w.rd_wr_req);
                errors++;
            end else if (e.w.rd_wr_req && (wrb_o.rd_addr !== e.w.rd_addr
                                           || wrb_o.rd_data !== e.w.rd_data)) begin
                $display("ERROR at %0t: write x%0d=%h, expected x%0d=%h", $time,
                         wrb_o.rd_addr, wrb_o.rd_data, e.w.rd_addr, e.w.rd_data);
                errors++;
            end
        end else if (wrb_o.rd_wr_req !== 1'b0) begin
            $display("ERROR at %0t: write request with nothing issued", $time);
            errors++;
        end
    end

    initial begin
        logic [`XLEN-1:0] x;
        logic [`XLEN-1:0] y;
        logic [2:0]       kind;
        rst_n_i = 1'b0;
        id2exe_ctrl_i = '0;
        id2exe_data_i = '0;
        lfsr = 16'd59;
        errors = 0;
        checks = 0;
        n_tests = 0;
        for (int i = 0; i < 32; i++) begin
            arch[i] = (i == 0) ? '0 : rand_bits(32);
            rf[i] = arch[i];
        end

        // A writing instruction presented in reset never reaches writeback
        begin_test("reset");
        @(posedge clk);
        #5;
        id2exe_ctrl_i = alu_ctrl(ALU_OPS_ADD, 1'b1);
        @(posedge clk);
        #5;
        rst_n_i = 1'b1;
        id2exe_ctrl_i = '0;
        idle_slot();
        idle_slot();
        end_test();

        // Sources x1 and x2 are never written here
        begin_test("alu opcodes");
        for (int i = 0; i < 12; i++) begin
            for (int m = 0; m < 2; m++) begin
                issue(alu_ctrl(type_alu_ops_e'(i), m[0]), 5'd1, 5'd2, 5'(10 + i),
                      rand_bits(32), rand_bits(32));
            end
        end
        end_test();

        begin_test("forwarding");
        issue(alu_ctrl(ALU_OPS_ADD, 1'b1), 5'd1, 5'd0, 5'd5, rand_bits(32), '0);
        issue(alu_ctrl(ALU_OPS_ADD, 1'b0), 5'd5, 5'd5, 5'd6, '0, '0);
        issue(alu_ctrl(ALU_OPS_SUB, 1'b0), 5'd5, 5'd6, 5'd7, '0, '0);
        // Both later stages write x8 and the memory stage must win
        issue(alu_ctrl(ALU_OPS_XOR, 1'b1), 5'd3, 5'd0, 5'd8, rand_bits(32), '0);
        issue(alu_ctrl(ALU_OPS_OR, 1'b1), 5'd4, 5'd0, 5'd8, rand_bits(32), '0);
        issue(alu_ctrl(ALU_OPS_ADD, 1'b0), 5'd8, 5'd8, 5'd9, '0, '0);
        // x0 reads stay zero after a write to x0
        issue(alu_ctrl(ALU_OPS_ADD, 1'b1), 5'd1, 5'd0, 5'd0, rand_bits(32), '0);
        issue(alu_ctrl(ALU_OPS_ADD, 1'b0), 5'd0, 5'd0, 5'd10, '0, '0);
        issue(alu_ctrl(ALU_OPS_OR, 1'b0), 5'd0, 5'd9, 5'd11, '0, '0);
        for (int i = 0; i < 40; i++) begin
            issue(alu_ctrl(type_alu_ops_e'(rand_bits(4) % 12), 1'(rand_bits(1))),
                  5'(rand_bits(3)), 5'(rand_bits(3)), 5'(rand_bits(3)), rand_bits(32),
                  rand_bits(32));
        end
        end_test();

        // Random, equal and sign boundary operands in both orders
        begin_test("branches");
        for (int br = 1; br <= 6; br++) begin
            for (int k = 0; k < 4; k++) begin
                x = rand_bits(32);
                y = (k == 1) ? x : rand_bits(32);
                if (k >= 2) begin
                    x = (k == 2) ? 32'h7fff_ffff : 32'h8000_0000;
                    y = ~x;
                end
                issue(alu_ctrl(ALU_OPS_COPY_OPR2, 1'b1), 5'd0, 5'd0, 5'd12, x, '0);
                issue(alu_ctrl(ALU_OPS_COPY_OPR2, 1'b1), 5'd0, 5'd0, 5'd13, y, '0);
                issue(br_ctrl(type_br_ops_e'(br)), 5'd12, 5'd13, 5'd0, rand_bits(32),
                      rand_bits(30) << 2);
            end
        end
        end_test();

        begin_test("jumps and bubbles");
        for (int i = 0; i < 4; i++) begin
            issue(jal_ctrl(1'b1), 5'd0, 5'd0, 5'(1 + i), rand_bits(32), rand_bits(30) << 2);
        end
        // Bubble writing x3 must not forward to the next read
        issue(jal_ctrl(1'b0), 5'd1, 5'd2, 5'd3, rand_bits(32), rand_bits(32));
        issue(alu_ctrl(ALU_OPS_ADD, 1'b0), 5'd3, 5'd3, 5'd4, '0, '0);
        issue(jal_ctrl(1'b0), 5'd1, 5'd2, 5'd3, rand_bits(32), rand_bits(32));
        issue(alu_ctrl(ALU_OPS_XOR, 1'b0), 5'd3, 5'd1, 5'd5, '0, '0);
        issue(alu_ctrl(ALU_OPS_OR, 1'b0), 5'd3, 5'd4, 5'd6, '0, '0);
        end_test();

        begin_test("random mix");
        for (int i = 0; i < 300; i++) begin
            kind = 3'(rand_bits(3));
            if (kind == 3'd4) begin
                issue(br_ctrl(type_br_ops_e'(1 + rand_bits(4) % 6)), 5'(rand_bits(3)),
                      5'(rand_bits(3)), 5'd0, rand_bits(32), rand_bits(30) << 2);
            end else if (kind == 3'd5 || kind == 3'd6) begin
                issue(jal_ctrl(kind == 3'd5), 5'(rand_bits(3)), 5'(rand_bits(3)),
                      5'(rand_bits(3)), rand_bits(32), rand_bits(30) << 2);
            end else begin
                issue(alu_ctrl(type_alu_ops_e'(rand_bits(4) % 12), 1'(rand_bits(1))),
                      5'(rand_bits(3)), 5'(rand_bits(3)), 5'(rand_bits(3)), rand_bits(32),
                      rand_bits(32));
            end
        end
        end_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_exe_subsys

`default_nettype wire

/* sources.f */
+incdir+verilog
+incdir+verification
verilog/exe_pkg.sv
verilog/forward_unit.sv
verilog/execute.sv
verilog/mem_wrb_pipe.sv
verilog/exe_subsys_top.sv
verification/tb_exe_subsys.sv

/* Makefile */
# Verilator build and run for the execute subsystem testbench

TOP = tb_exe_subsys

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -sv -f sources.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log

lint:
	verilator --lint-only --timing -sv -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
